/* design/lx_cache_pkg.sv */
/*
 * Shared definitions for the second-level cache
 * Cache geometry and derived widths
 * Address, tag, index, way and port types
 * Stored line layout and message codes
 */

package lx_cache_pkg;

	// Word addresses, four words per line
	localparam int ADDR_WIDTH     = 32;
	localparam int WORD_WIDTH     = 32;
	localparam int OFFSET_BITS    = 2;
	localparam int WORDS_PER_LINE = 1 << OFFSET_BITS;

	localparam int INDEX_BITS = 4;
	localparam int NUM_SETS   = 1 << INDEX_BITS;
	localparam int NUM_WAYS   = 2;
	localparam int WAY_BITS   = $clog2(NUM_WAYS);
	localparam int TAG_BITS   = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

	// Upper caches sharing this level
	localparam int NUM_CACHES = 2;
	localparam int PORT_BITS  = $clog2(NUM_CACHES);

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [TAG_BITS-1:0]   tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [WAY_BITS-1:0]   way_t;
	typedef logic [PORT_BITS-1:0]  port_t;

	typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_data_t;

	// Valid and dirty sit above the tag
	typedef struct packed {
		logic       valid;
		logic       dirty;
		tag_t       tag;
		line_data_t data;
	} line_t;

	typedef enum logic [2:0] {
		NO_REQ     = 3'd0,
		R_REQ      = 3'd1,
		WB_REQ     = 3'd2,
		MEM_NO_MSG = 3'd4,
		MEM_SENT   = 3'd5,
		MEM_READY  = 3'd6
	} msg_t;

endpackage

/* design/way_lookup_if.sv */
/*
 * Lookup and write path between the controller and the way store
 * Modports for both sides
 */

`timescale 1ns/1ns

interface way_lookup_if;
	import lx_cache_pkg::*;

	index_t lookup_index;
	logic   write_en;
	way_t   write_way;
	line_t  write_line;

	// One line per way, registered
	line_t  read_lines [NUM_WAYS];
	logic   hit;
	way_t   hit_way;
	logic   sweep_done;

	modport controller (
		output lookup_index, write_en, write_way, write_line,
		input  read_lines, hit, hit_way, sweep_done
	);

	modport store (
		input  lookup_index, write_en, write_way, write_line,
		output read_lines, hit, hit_way, sweep_done
	);

endinterface

/* design/request_arbiter.sv */
/*
 * Round-robin arbiter for the upper-cache ports
 * Combinational grant, pointer moves on accept
 */

`timescale 1ns/1ns

module request_arbiter (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [lx_cache_pkg::NUM_CACHES-1:0]   requesting,
	input  logic                                  accept,
	output lx_cache_pkg::port_t                   grant_port
);
	import lx_cache_pkg::*;

	port_t pointer;

	// First requester at or after the pointer
	always_comb begin
		int idx;
		grant_port = pointer;
		for (int i = NUM_CACHES - 1; i >= 0; i--) begin
			idx = (int'(pointer) + i) % NUM_CACHES;
			if (requesting[idx])
				grant_port = port_t'(idx);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pointer <= '0;
		end else if (accept) begin
			if (grant_port == port_t'(NUM_CACHES - 1))
				pointer <= '0;
			else
				pointer <= grant_port + 1'b1;
		end
	end

	// Controller never accepts an empty request set
	assert property (@(posedge clock) disable iff (reset)
		accept |-> |requesting);

endmodule

/* design/way_store.sv */
/*
 * Line storage for all ways
 * Synchronous read per way, tag compare and hit way
 * Post-reset sweep that invalidates every set
 */

`timescale 1ns/1ns

module way_store (
	input  logic                 clock,
	input  logic                 reset,
	way_lookup_if.store          lookup,
	input  lx_cache_pkg::tag_t   lookup_tag
);
	import lx_cache_pkg::*;

	index_t              sweep_index;
	logic [NUM_WAYS-1:0] way_hit;

	// One set cleared per cycle after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			sweep_index       <= '0;
			lookup.sweep_done <= 1'b0;
		end else if (!lookup.sweep_done) begin
			sweep_index <= sweep_index + 1'b1;
			if (sweep_index == index_t'(NUM_SETS - 1))
				lookup.sweep_done <= 1'b1;
		end
	end

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		line_t ram [NUM_SETS];
		line_t read_line;

		always_ff @(posedge clock) begin
			if (!lookup.sweep_done)
				ram[sweep_index] <= '0;
			else if (lookup.write_en && lookup.write_way == way_t'(w))
				ram[lookup.lookup_index] <= lookup.write_line;
			read_line <= ram[lookup.lookup_index];
		end

		assign lookup.read_lines[w] = read_line;
		assign way_hit[w] = read_line.valid && (read_line.tag == lookup_tag);
	end

	always_comb begin
		lookup.hit     = |way_hit;
		lookup.hit_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w])
				lookup.hit_way = way_t'(w);
		end
	end

	// A tag lives in at most one way of a set
	assert property (@(posedge clock) disable iff (reset || !lookup.sweep_done)
		$onehot0(way_hit));

endmodule

/* design/lru_tracker.sv */
/*
 * Least-recently-used order per set
 * Victim selection, preferring an invalid way
 */

`timescale 1ns/1ns

module lru_tracker (
	input  logic                                clock,
	input  logic                                reset,
	input  lx_cache_pkg::index_t                access_index,
	input  lx_cache_pkg::way_t                  access_way,
	input  logic                                access_valid,
	input  logic [lx_cache_pkg::NUM_WAYS-1:0]   set_valid,
	output lx_cache_pkg::way_t                  victim_way
);
	import lx_cache_pkg::*;

	// Age 0 is youngest, NUM_WAYS-1 is oldest
	way_t age [NUM_SETS][NUM_WAYS];

	always_comb begin
		victim_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (age[access_index][w] == way_t'(NUM_WAYS - 1))
				victim_way = way_t'(w);
		end
		// Lowest invalid way wins over the oldest
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!set_valid[w])
				victim_way = way_t'(w);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++)
					age[s][w] <= way_t'(w);
			end
		end else if (access_valid) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (way_t'(w) == access_way)
					age[access_index][w] <= '0;
				else if (age[access_index][w] < age[access_index][access_way])
					age[access_index][w] <= age[access_index][w] + 1'b1;
			end
		end
	end

endmodule

/* design/cache_controller.sv */
/*
 * Request FSM for the shared cache
 * Hit service, dirty victim write-back, refill and install
 * Upper-cache responses and memory request sequencing
 */

`timescale 1ns/1ns

module cache_controller (
	input  logic                       clock,
	input  logic                       reset,
	input  lx_cache_pkg::msg_t         req_msg [lx_cache_pkg::NUM_CACHES],
	input  lx_cache_pkg::addr_t        req_addr [lx_cache_pkg::NUM_CACHES],
	input  lx_cache_pkg::line_data_t   req_data [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::msg_t         resp_msg [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::addr_t        resp_addr [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::line_data_t   resp_data [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::msg_t         mem_req_msg,
	output lx_cache_pkg::addr_t        mem_req_addr,
	output lx_cache_pkg::line_data_t   mem_req_data,
	input  lx_cache_pkg::msg_t         mem_resp_msg,
	input  lx_cache_pkg::line_data_t   mem_resp_data,
	input  lx_cache_pkg::port_t        grant_port,
	output logic                       accept,
	way_lookup_if.controller           lookup,
	output lx_cache_pkg::tag_t         lookup_tag,
	input  lx_cache_pkg::way_t         victim_way,
	output lx_cache_pkg::index_t       access_index,
	output lx_cache_pkg::way_t         access_way,
	output logic                       access_valid
);
	import lx_cache_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_SERVE, S_WRITE_BACK, S_REFILL_WAIT, S_INSTALL, S_RESP_READ, S_RESP_WRITE
	} state_t;

	state_t                state;
	port_t                 cur_port;
	logic                  cur_write;
	addr_t                 cur_addr;
	line_data_t            line_buf;
	way_t                  target_way;
	logic [NUM_CACHES-1:0] resp_active;
	index_t                cur_index;
	tag_t                  cur_tag;
	line_t                 victim_line;
	logic                  dirty_victim;
	addr_t                 line_addr;
	addr_t                 victim_addr;

	for (genvar p = 0; p < NUM_CACHES; p++) begin : g_resp
		assign resp_active[p] = (resp_msg[p] != MEM_NO_MSG);
	end

	assign cur_index    = cur_addr[OFFSET_BITS +: INDEX_BITS];
	assign cur_tag      = cur_addr[ADDR_WIDTH-1 -: TAG_BITS];
	assign line_addr    = {cur_tag, cur_index, {OFFSET_BITS{1'b0}}};
	assign victim_line  = lookup.read_lines[victim_way];
	assign dirty_victim = victim_line.valid && victim_line.dirty;
	assign victim_addr  = {victim_line.tag, cur_index, {OFFSET_BITS{1'b0}}};

	// New work only once the previous response has gone
	assign accept = (state == S_IDLE) && lookup.sweep_done && !(|resp_active)
		&& (req_msg[grant_port] == R_REQ || req_msg[grant_port] == WB_REQ);

	// Idle looks up the granted port so the lines are ready in serve
	assign lookup.lookup_index = (state == S_IDLE)
		? req_addr[grant_port][OFFSET_BITS +: INDEX_BITS] : cur_index;
	assign lookup_tag = cur_tag;

	assign lookup.write_en   = (state == S_SERVE && cur_write && lookup.hit)
		|| (state == S_INSTALL);
	assign lookup.write_way  = (state == S_SERVE) ? lookup.hit_way : target_way;
	assign lookup.write_line = '{valid: 1'b1, dirty: cur_write, tag: cur_tag, data: line_buf};

	assign access_index = cur_index;
	assign access_way   = lookup.write_way;
	assign access_valid = (state == S_SERVE && lookup.hit) || (state == S_INSTALL);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= S_IDLE;
			mem_req_msg <= NO_REQ;
			for (int p = 0; p < NUM_CACHES; p++)
				resp_msg[p] <= MEM_NO_MSG;
		end else begin
			// Responses last a single cycle
			for (int p = 0; p < NUM_CACHES; p++)
				resp_msg[p] <= MEM_NO_MSG;
			case (state)
				S_IDLE:
					if (accept)
						state <= S_SERVE;
				S_SERVE:
					if (lookup.hit) begin
						state <= cur_write ? S_RESP_WRITE : S_RESP_READ;
					end else if (dirty_victim) begin
						mem_req_msg <= WB_REQ;
						state       <= S_WRITE_BACK;
					end else if (!cur_write) begin
						mem_req_msg <= R_REQ;
						state       <= S_REFILL_WAIT;
					end else begin
						state <= S_INSTALL;
					end
				S_WRITE_BACK:
					if (mem_resp_msg == MEM_READY) begin
						mem_req_msg <= cur_write ? NO_REQ : R_REQ;
						state       <= cur_write ? S_INSTALL : S_REFILL_WAIT;
					end
				S_REFILL_WAIT:
					if (mem_resp_msg == MEM_SENT) begin
						mem_req_msg <= NO_REQ;
						state       <= S_INSTALL;
					end
				S_INSTALL:
					state <= cur_write ? S_RESP_WRITE : S_RESP_READ;
				S_RESP_READ: begin
					resp_msg[cur_port] <= MEM_SENT;
					state              <= S_IDLE;
				end
				S_RESP_WRITE: begin
					resp_msg[cur_port] <= MEM_READY;
					state              <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			S_IDLE:
				if (accept) begin
					cur_port  <= grant_port;
					cur_addr  <= req_addr[grant_port];
					cur_write <= (req_msg[grant_port] == WB_REQ);
					line_buf  <= req_data[grant_port];
				end
			S_SERVE: begin
				target_way <= victim_way;
				if (lookup.hit && !cur_write)
					line_buf <= lookup.read_lines[lookup.hit_way].data;
				mem_req_addr <= dirty_victim ? victim_addr : line_addr;
				mem_req_data <= victim_line.data;
			end
			S_WRITE_BACK:
				if (mem_resp_msg == MEM_READY)
					mem_req_addr <= line_addr;
			S_REFILL_WAIT:
				if (mem_resp_msg == MEM_SENT)
					line_buf <= mem_resp_data;
			S_RESP_READ, S_RESP_WRITE: begin
				resp_addr[cur_port] <= cur_addr;
				resp_data[cur_port] <= line_buf;
			end
			default: ;
		endcase
	end

	assert property (@(posedge clock) disable iff (reset)
		$onehot0(resp_active));

	// Memory request held until memory answers
	assert property (@(posedge clock) disable iff (reset)
		(mem_req_msg != NO_REQ && mem_resp_msg != MEM_SENT && mem_resp_msg != MEM_READY)
		|=> $stable(mem_req_msg) && $stable(mem_req_addr) && $stable(mem_req_data));

endmodule

/* design/lx_cache.sv */
/*
 * Shared second-level cache top level
 * Arbiter, way store, LRU tracker and controller
 */

`timescale 1ns/1ns

module lx_cache (
	input  logic                       clock,
	input  logic                       reset,
	input  lx_cache_pkg::msg_t         req_msg [lx_cache_pkg::NUM_CACHES],
	input  lx_cache_pkg::addr_t        req_addr [lx_cache_pkg::NUM_CACHES],
	input  lx_cache_pkg::line_data_t   req_data [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::msg_t         resp_msg [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::addr_t        resp_addr [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::line_data_t   resp_data [lx_cache_pkg::NUM_CACHES],
	output lx_cache_pkg::msg_t         mem_req_msg,
	output lx_cache_pkg::addr_t        mem_req_addr,
	output lx_cache_pkg::line_data_t   mem_req_data,
	input  lx_cache_pkg::msg_t         mem_resp_msg,
	input  lx_cache_pkg::line_data_t   mem_resp_data
);
	import lx_cache_pkg::*;

	logic [NUM_CACHES-1:0] requesting;
	logic [NUM_WAYS-1:0]   set_valid;
	port_t                 grant_port;
	logic                  accept;
	tag_t                  lookup_tag;
	way_t                  victim_way;
	index_t                access_index;
	way_t                  access_way;
	logic                  access_valid;

	way_lookup_if lookup_bus ();

	for (genvar p = 0; p < NUM_CACHES; p++) begin : g_port
		assign requesting[p] = (req_msg[p] == R_REQ) || (req_msg[p] == WB_REQ);
	end

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_valid
		assign set_valid[w] = lookup_bus.read_lines[w].valid;
	end

	request_arbiter arbiter_i (.clock, .reset, .requesting, .accept, .grant_port);

	way_store store_i (.clock, .reset, .lookup(lookup_bus.store), .lookup_tag);

	lru_tracker lru_i (
		.clock, .reset, .access_index, .access_way, .access_valid, .set_valid, .victim_way
	);

	cache_controller controller_i (
		.clock, .reset,
		.req_msg, .req_addr, .req_data,
		.resp_msg, .resp_addr, .resp_data,
		.mem_req_msg, .mem_req_addr, .mem_req_data,
		.mem_resp_msg, .mem_resp_data,
		.grant_port, .accept,
		.lookup(lookup_bus.controller), .lookup_tag,
		.victim_way, .access_index, .access_way, .access_valid
	);

endmodule

/* sim/lx_cache_tb.sv */
/*
 * Testbench for the shared second-level cache
 * Clock, reset and a memory model with random latency
 * Directed tests for hits, refills, eviction, arbitration and mixed traffic
 */

`timescale 1ns/1ns

module lx_cache_tb;
	import lx_cache_pkg::*;

	localparam int REQ_TIMEOUT = 300;
	localparam int TRAFFIC_OPS = 40;

	logic       clock;
	logic       reset;
	msg_t       req_msg [NUM_CACHES];
	addr_t      req_addr [NUM_CACHES];
	line_data_t req_data [NUM_CACHES];
	msg_t       resp_msg [NUM_CACHES];
	addr_t      resp_addr [NUM_CACHES];
	line_data_t resp_data [NUM_CACHES];
	msg_t       mem_req_msg;
	addr_t      mem_req_addr;
	line_data_t mem_req_data;
	msg_t       mem_resp_msg;
	line_data_t mem_resp_data;

	// Memory contents, last written data per line, and answered memory requests
	line_data_t mem_lines [addr_t];
	line_data_t shadow [addr_t];
	msg_t       mem_log_msg [$];
	addr_t      mem_log_addr [$];
	line_data_t mem_log_data [$];

	int cycle = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	lx_cache dut_i (
		.clock, .reset,
		.req_msg, .req_addr, .req_data,
		.resp_msg, .resp_addr, .resp_data,
		.mem_req_msg, .mem_req_addr, .mem_req_data,
		.mem_resp_msg, .mem_resp_data
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	function automatic addr_t line_of(addr_t addr);
		return {addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	endfunction

	function automatic addr_t make_addr(tag_t tag, index_t index, int offset);
		return {tag, index, OFFSET_BITS'(offset)};
	endfunction

	function automatic line_data_t random_line();
		line_data_t line;
		for (int w = 0; w < WORDS_PER_LINE; w++)
			line[w] = $urandom;
		return line;
	endfunction

	// Unwritten lines read as random data, kept from then on
	function automatic line_data_t memory_line(addr_t line);
		if (!mem_lines.exists(line))
			mem_lines[line] = random_line();
		return mem_lines[line];
	endfunction

	function automatic line_data_t expected_line(addr_t addr);
		if (shadow.exists(line_of(addr)))
			return shadow[line_of(addr)];
		if (mem_lines.exists(line_of(addr)))
			return mem_lines[line_of(addr)];
		return 'x;
	endfunction

	// Answers each request after 0 to 5 cycles, response held one cycle
	task automatic serve_memory();
		int unsigned wait_left;
		bit          busy;
		busy = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge clock);
			#2;
			if (mem_resp_msg != MEM_NO_MSG) begin
				mem_resp_msg = MEM_NO_MSG;
				busy = 1'b0;
			end else if (!reset && mem_req_msg != NO_REQ) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = $urandom_range(5, 0);
				end
				if (wait_left > 0) begin
					wait_left--;
				end else begin
					mem_log_msg.push_back(mem_req_msg);
					mem_log_addr.push_back(mem_req_addr);
					mem_log_data.push_back(mem_req_data);
					if (mem_req_msg == WB_REQ) begin
						mem_lines[mem_req_addr] = mem_req_data;
						mem_resp_msg = MEM_READY;
					end else begin
						mem_resp_data = memory_line(mem_req_addr);
						mem_resp_msg = MEM_SENT;
					end
				end
			end
		end
	endtask

	task automatic issue_request(input int port, input msg_t msg, input addr_t addr,
			input line_data_t data, output line_data_t got, output addr_t got_addr,
			output bit ok, output int done_cycle);
		msg_t expect_resp;
		int   waited;
		expect_resp = (msg == R_REQ) ? MEM_SENT : MEM_READY;
		@(posedge clock);
		#2;
		req_msg[port] = msg;
		req_addr[port] = addr;
		req_data[port] = data;
		ok = 1'b0;
		waited = 0;
		while (!ok && waited < REQ_TIMEOUT) begin
			@(posedge clock);
			#2;
			waited++;
			if (resp_msg[port] != MEM_NO_MSG)
				ok = 1'b1;
		end
		req_msg[port] = NO_REQ;
		got = resp_data[port];
		got_addr = resp_addr[port];
		done_cycle = cycle;
		if (!ok) begin
			$display("Port %0d got no response to its request for %h", port, addr);
			errors++;
		end else if (resp_msg[port] !== expect_resp) begin
			$display("ERR resp_msg[%0d] expected %h got %h", port, expect_resp, resp_msg[port]);
			errors++;
		end
	endtask

	task automatic store_line(input int port, input addr_t addr, input line_data_t data,
			output int done_cycle);
		line_data_t got;
		addr_t      got_addr;
		bit         ok;
		issue_request(port, WB_REQ, addr, data, got, got_addr, ok, done_cycle);
		if (ok)
			shadow[line_of(addr)] = data;
	endtask

	task automatic check_read(input int port, input addr_t addr, output int done_cycle);
		line_data_t got;
		line_data_t exp;
		addr_t      got_addr;
		bit         ok;
		issue_request(port, R_REQ, addr, '0, got, got_addr, ok, done_cycle);
		if (ok) begin
			exp = expected_line(addr);
			if (got !== exp) begin
				$display("ERR resp_data[%0d] expected %h got %h", port, exp, got);
				errors++;
			end
			if (got_addr !== addr) begin
				$display("ERR resp_addr[%0d] expected %h got %h", port, addr, got_addr);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic check_reset_state();
		int start;
		start = errors;
		for (int p = 0; p < NUM_CACHES; p++) begin
			if (resp_msg[p] !== MEM_NO_MSG) begin
				$display("ERR resp_msg[%0d] expected %h got %h", p, MEM_NO_MSG, resp_msg[p]);
				errors++;
			end
		end
		if (mem_req_msg !== NO_REQ) begin
			$display("ERR mem_req_msg expected %h got %h", NO_REQ, mem_req_msg);
			errors++;
		end
		report_test("reset state", start);
	endtask

	task automatic round_robin_service();
		addr_t      read_addr;
		addr_t      write_addr;
		line_data_t data;
		int         c0;
		int         c1;
		int         start;
		start = errors;
		read_addr = make_addr('h0a1, 3, 0);
		write_addr = make_addr('h0b2, 4, 1);
		data = random_line();
		fork
			check_read(0, read_addr, c0);
			store_line(1, write_addr, data, c1);
		join
		if (c0 >= c1) begin
			$display("Port 1 was answered before port 0");
			errors++;
		end
		check_read(1, write_addr, c1);
		report_test("round robin", start);
	endtask

	task automatic write_read_hit();
		addr_t addr;
		int    c;
		int    logged;
		int    start;
		start = errors;
		addr = make_addr('h123, 1, 2);
		store_line(0, addr, random_line(), c);
		logged = mem_log_msg.size();
		check_read(0, addr, c);
		if (mem_log_msg.size() != logged) begin
			$display("Memory saw a request during a read hit");
			errors++;
		end
		report_test("write then read hit", start);
	endtask

	task automatic read_miss_refill();
		addr_t addr;
		int    c;
		int    logged;
		int    reads;
		int    start;
		start = errors;
		addr = make_addr('h2c4, 2, 0);
		logged = mem_log_msg.size();
		check_read(0, addr, c);
		reads = 0;
		for (int i = logged; i < mem_log_msg.size(); i++) begin
			if (mem_log_msg[i] == R_REQ && mem_log_addr[i] == line_of(addr))
				reads++;
		end
		if (mem_log_msg.size() - logged != 1 || reads != 1) begin
			$display("Expected one memory read for the missed line, saw %0d requests",
				mem_log_msg.size() - logged);
			errors++;
		end
		report_test("read miss refill", start);
	endtask

	task automatic dirty_eviction();
		addr_t      addrs [NUM_WAYS+1];
		line_data_t data [NUM_WAYS+1];
		int         c;
		int         logged;
		int         start;
		start = errors;
		logged = mem_log_msg.size();
		for (int i = 0; i <= NUM_WAYS; i++) begin
			addrs[i] = make_addr('h300 + i, 5, 0);
			data[i] = random_line();
			store_line(0, addrs[i], data[i], c);
		end
		check_read(0, addrs[0], c);
		if (mem_log_msg.size() <= logged) begin
			$display("No write-back reached memory");
			errors++;
		end else begin
			if (mem_log_msg[logged] !== WB_REQ) begin
				$display("ERR mem_req_msg expected %h got %h", WB_REQ, mem_log_msg[logged]);
				errors++;
			end
			if (mem_log_addr[logged] !== addrs[0]) begin
				$display("ERR mem_req_addr expected %h got %h", addrs[0], mem_log_addr[logged]);
				errors++;
			end
			if (mem_log_data[logged] !== data[0]) begin
				$display("ERR mem_req_data expected %h got %h", data[0], mem_log_data[logged]);
				errors++;
			end
		end
		report_test("dirty eviction", start);
	endtask

	// Four tags in each of sets 8 and 9
	task automatic random_traffic(input int port);
		addr_t addr;
		int    c;
		for (int i = 0; i < TRAFFIC_OPS; i++) begin
			addr = make_addr('h400 + $urandom_range(3, 0), 8 + $urandom_range(1, 0), 0);
			if ($urandom_range(1, 0))
				store_line(port, addr, random_line(), c);
			else
				check_read(port, addr, c);
		end
	endtask

	task automatic mixed_traffic();
		int start;
		start = errors;
		fork
			random_traffic(0);
			random_traffic(1);
		join
		report_test("mixed traffic", start);
	endtask

	initial begin
		void'($urandom(32'h3eb0));
		reset = 1'b1;
		mem_resp_msg = MEM_NO_MSG;
		mem_resp_data = '0;
		for (int p = 0; p < NUM_CACHES; p++) begin
			req_msg[p] = NO_REQ;
			req_addr[p] = '0;
			req_data[p] = '0;
		end
		fork
			serve_memory();
		join_none
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;
		check_reset_state();
		// Pointer still at port 0 here
		round_robin_service();
		write_read_hit();
		read_miss_refill();
		dirty_eviction();
		mixed_traffic();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* all.f */
design/lx_cache_pkg.sv
design/way_lookup_if.sv
design/request_arbiter.sv
design/way_store.sv
design/lru_tracker.sv
design/cache_controller.sv
design/lx_cache.sv
sim/lx_cache_tb.sv

/* Bender.yml */
package:
  name: lx_cache

sources:
  - design/lx_cache_pkg.sv
  - design/way_lookup_if.sv
  - design/request_arbiter.sv
  - design/way_store.sv
  - design/lru_tracker.sv
  - design/cache_controller.sv
  - design/lx_cache.sv
  - target: simulation
    files:
      - sim/lx_cache_tb.sv
